// ==== rtl/nnFormatPkg.sv ====
package nnFormatPkg;

	// Features, weights, products and sums all share this width
	localparam int DataWidth = 32;

	// Width of one neuron activation after the ReLU
	localparam int ActWidth = 16;

	// Lowest sum bit that is kept in the activation
	// The kept field runs from FracBits up to FracBits + ActWidth - 1
	localparam int FracBits = 13;

	// Signed two's complement word, wraps on overflow
	typedef logic signed [DataWidth-1:0] featureT;

	// Activations are never negative after the ReLU
	typedef logic [ActWidth-1:0] actT;

endpackage

// ==== rtl/layerWeightsPkg.sv ====
package layerWeightsPkg;

	// Features per input vector
	localparam int NumInputs = 8;

	// Neurons in the layer, one output class each
	localparam int NumNeurons = 4;

	// Enough bits to index every neuron
	localparam int ClassWidth = 2;

	// One row per neuron, column i multiplies feature i
	localparam nnFormatPkg::featureT [0:NumNeurons-1][0:NumInputs-1] LayerWeights = '{
		'{
			3712, -1455, 6821, -508,
			-3127, 914, -1376, 2248
		},
		'{
			1087, 2964, -2215, 5530,
			-744, -1902, 3371, 419
		},
		'{
			-2683, 4406, 1139, -3358,
			5017, 266, -1791, 2930
		},
		'{
			4875, -617, -2459, 1548,
			3303, -4092, 702, 6164
		}
	};

	// Bias added to each neuron's weighted sum
	localparam nnFormatPkg::featureT [0:NumNeurons-1] LayerBias = '{
		-152,
		408,
		-271,
		63
	};

endpackage

// ==== rtl/featureCollector.sv ====
module featureCollector
	import nnFormatPkg::*;
#(
	parameter int NumInputs = 8
)
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     featureValid,
	input  featureT                  featureData,
	output logic                     vectorDone,
	output featureT [NumInputs-1:0]  vectorData
);

	localparam int CountWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1;
	localparam logic [CountWidth-1:0] LastIndex = CountWidth'(NumInputs - 1);

	// Index of the next feature word in the vector
	logic [CountWidth-1:0] count;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count      <= '0;
			vectorDone <= 1'b0;
		end
		else
		begin
			vectorDone <= 1'b0;
			if (featureValid)
			begin
				if (count == LastIndex)
				begin
					// Last word of the vector, start over with index 0
					count      <= '0;
					vectorDone <= 1'b1;
				end
				else
				begin
					count <= count + 1'b1;
				end
			end
		end
	end

	// Each strobed word lands in the slot of its index
	always_ff @(posedge clk)
	begin
		if (featureValid)
		begin
			vectorData[count] <= featureData;
		end
	end

	// Counter must wrap before it runs past the last feature
	countInRange: assert property (
		@(posedge clk) disable iff (reset)
		count <= LastIndex
	)
	else $error("featureCollector count out of range: %0d", count);

endmodule

// ==== rtl/vectorLatch.sv ====
module vectorLatch
	import nnFormatPkg::*;
#(
	parameter int NumInputs = 8
)
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     vectorDone,
	input  featureT [NumInputs-1:0]  vectorData,
	output logic                     layerStart,
	output featureT [NumInputs-1:0]  layerInputs
);

	// Start pulse trails the capture by one cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			layerStart <= 1'b0;
		end
		else
		begin
			layerStart <= vectorDone;
		end
	end

	// Holds the completed vector while the collector refills
	always_ff @(posedge clk)
	begin
		if (vectorDone)
		begin
			layerInputs <= vectorData;
		end
	end

	// Vectors are at least NumInputs cycles apart so starts never merge
	singleStartPulse: assert property (
		@(posedge clk) disable iff (reset)
		layerStart |=> !layerStart
	)
	else $error("vectorLatch layerStart high for two cycles");

endmodule

// ==== rtl/neuron.sv ====
module neuron
	import nnFormatPkg::*;
#(
	parameter int                        NumInputs = 8,
	parameter featureT [0:NumInputs-1]   Weights   = '0,
	parameter featureT                   Bias      = '0
)
(
	input  logic                     clk,
	input  logic                     reset,
	input  featureT [NumInputs-1:0]  inputs,
	output actT                      activation
);

	// Highest sum bit kept in the activation
	localparam int ActMsb = FracBits + ActWidth - 1;

	featureT [NumInputs-1:0] inputsReg;
	featureT                 sumNext;
	featureT                 sumReg;

	// Stage 1 registers the inputs
	always_ff @(posedge clk)
	begin
		inputsReg <= inputs;
	end

	// Weighted sum plus bias, wrapping at 32 bits
	always_comb
	begin
		sumNext = Bias;
		for (int i = 0; i < NumInputs; i++)
		begin
			sumNext = sumNext + inputsReg[i] * Weights[i];
		end
	end

	// Stage 2 registers the sum
	always_ff @(posedge clk)
	begin
		sumReg <= sumNext;
	end

	// Stage 3 applies the ReLU and takes the fixed-point slice
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
		end
		else if (sumReg[DataWidth-1])
		begin
			activation <= '0;
		end
		else
		begin
			activation <= sumReg[ActMsb:FracBits];
		end
	end

endmodule

// ==== rtl/denseLayer.sv ====
module denseLayer
	import nnFormatPkg::*;
	import layerWeightsPkg::*;
#(
	parameter int NumInputs  = layerWeightsPkg::NumInputs,
	parameter int NumNeurons = layerWeightsPkg::NumNeurons,
	parameter int ClassWidth = layerWeightsPkg::ClassWidth,
	parameter featureT [0:NumNeurons-1][0:NumInputs-1] Weights = LayerWeights,
	parameter featureT [0:NumNeurons-1]                Biases  = LayerBias
)
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      layerStart,
	input  featureT [NumInputs-1:0]   layerInputs,
	output logic                      resultValid,
	output actT [NumNeurons-1:0]      activations,
	output logic [ClassWidth-1:0]     classIndex
);

	actT [NumNeurons-1:0]  neuronActs;
	logic [2:0]            validPipe;
	actT                   bestAct;
	logic [ClassWidth-1:0] bestIndex;

	for (genvar n = 0; n < NumNeurons; n++)
	begin : gNeuron
		neuron #(
			.NumInputs(NumInputs),
			.Weights  (Weights[n]),
			.Bias     (Biases[n])
		) uNeuron (
			.clk       (clk),
			.reset     (reset),
			.inputs    (layerInputs),
			.activation(neuronActs[n])
		);
	end

	// Strict compare keeps the lowest index on a tie
	always_comb
	begin
		bestAct   = neuronActs[0];
		bestIndex = '0;
		for (int n = 1; n < NumNeurons; n++)
		begin
			if (neuronActs[n] > bestAct)
			begin
				bestAct   = neuronActs[n];
				bestIndex = ClassWidth'(n);
			end
		end
	end

	// Valid bit follows the three neuron stages
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe   <= '0;
			resultValid <= 1'b0;
			activations <= '0;
			classIndex  <= '0;
		end
		else
		begin
			validPipe   <= {validPipe[1:0], layerStart};
			resultValid <= validPipe[2];
			if (validPipe[2])
			begin
				activations <= neuronActs;
				classIndex  <= bestIndex;
			end
		end
	end

	classInRange: assert property (
		@(posedge clk) disable iff (reset)
		resultValid |-> (classIndex < NumNeurons)
	)
	else $error("denseLayer classIndex out of range: %0d", classIndex);

endmodule

// ==== rtl/neuralLayerTop.sv ====
module neuralLayerTop
	import nnFormatPkg::*;
	import layerWeightsPkg::*;
#(
	parameter int NumInputs  = layerWeightsPkg::NumInputs,
	parameter int NumNeurons = layerWeightsPkg::NumNeurons,
	parameter int ClassWidth = layerWeightsPkg::ClassWidth,
	parameter featureT [0:NumNeurons-1][0:NumInputs-1] Weights = LayerWeights,
	parameter featureT [0:NumNeurons-1]                Biases  = LayerBias
)
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      featureValid,
	input  featureT                   featureData,
	output logic                      resultValid,
	output actT [NumNeurons-1:0]      activations,
	output logic [ClassWidth-1:0]     classIndex
);

	logic                    vectorDone;
	featureT [NumInputs-1:0] vectorData;
	logic                    layerStart;
	featureT [NumInputs-1:0] layerInputs;

	featureCollector #(
		.NumInputs(NumInputs)
	) uCollector (
		.clk         (clk),
		.reset       (reset),
		.featureValid(featureValid),
		.featureData (featureData),
		.vectorDone  (vectorDone),
		.vectorData  (vectorData)
	);

	vectorLatch #(
		.NumInputs(NumInputs)
	) uLatch (
		.clk        (clk),
		.reset      (reset),
		.vectorDone (vectorDone),
		.vectorData (vectorData),
		.layerStart (layerStart),
		.layerInputs(layerInputs)
	);

	denseLayer #(
		.NumInputs (NumInputs),
		.NumNeurons(NumNeurons),
		.ClassWidth(ClassWidth),
		.Weights   (Weights),
		.Biases    (Biases)
	) uLayer (
		.clk        (clk),
		.reset      (reset),
		.layerStart (layerStart),
		.layerInputs(layerInputs),
		.resultValid(resultValid),
		.activations(activations),
		.classIndex (classIndex)
	);

endmodule

// ==== sim/neuralLayerTb.sv ====
module neuralLayerTb
	import nnFormatPkg::*;
	import layerWeightsPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NumCases      = 9;
	localparam int CaseWords     = NumInputs + NumNeurons + 1;
	localparam int ResultTimeout = 50;
	localparam int ResetCycles   = 5;
	localparam int PipeEdges     = 6;

	logic                  clk;
	logic                  reset;
	logic                  featureValid;
	featureT               featureData;
	logic                  resultValid;
	actT [NumNeurons-1:0]  activations;
	logic [ClassWidth-1:0] classIndex;

	// Per case: features, then expected activations, then expected class
	logic [31:0] caseMem [0:NumCases*CaseWords-1];

	logic [31:0] lcgState;
	int          errorCount;
	int          testsPassed;
	int          testsFailed;

	neuralLayerTop u_dut (
		.clk         (clk),
		.reset       (reset),
		.featureValid(featureValid),
		.featureData (featureData),
		.resultValid (resultValid),
		.activations (activations),
		.classIndex  (classIndex)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Drive and sample point, 2 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic sendVector(input int caseIdx, input bit withGaps);
		int gap;
		for (int i = 0; i < NumInputs; i++)
		begin
			featureValid = 1'b1;
			featureData  = featureT'(caseMem[caseIdx*CaseWords + i]);
			tick();
			featureValid = 1'b0;
			// Idle data must be ignored by the collector
			featureData  = featureT'(32'hDEADBEEF);
			if (withGaps)
			begin
				lcgState = lcgStep(lcgState);
				gap      = int'(lcgState[17:16]);
				repeat (gap) tick();
			end
		end
	endtask

	task automatic checkIdle();
		if (resultValid !== 1'b0)
		begin
			$display("error resultValid: expected 0x0, got 0x%h", resultValid);
			errorCount++;
		end
		if (activations !== '0)
		begin
			$display("error activations: expected 0x0, got 0x%h", activations);
			errorCount++;
		end
		if (classIndex !== '0)
		begin
			$display("error classIndex: expected 0x0, got 0x%h", classIndex);
			errorCount++;
		end
	endtask

	task automatic waitForResult(input bit idleZero, output int edges, output bit seen);
		edges = 0;
		seen  = 1'b0;
		while (!seen && edges < ResultTimeout)
		begin
			tick();
			edges++;
			if (resultValid === 1'b1)
			begin
				seen = 1'b1;
			end
			else if (idleZero)
			begin
				checkIdle();
			end
		end
		if (!seen)
		begin
			$display("timeout: no resultValid pulse within %0d cycles", ResultTimeout);
			errorCount++;
		end
	endtask

	task automatic checkResult(input int caseIdx);
		int                    base;
		actT                   expAct;
		logic [ClassWidth-1:0] expClass;
		base = caseIdx*CaseWords + NumInputs;
		for (int n = 0; n < NumNeurons; n++)
		begin
			expAct = actT'(caseMem[base + n]);
			if (activations[n] !== expAct)
			begin
				$display("error activations[%0d]: expected 0x%h, got 0x%h (case %0d)",
					n, expAct, activations[n], caseIdx);
				errorCount++;
			end
		end
		expClass = ClassWidth'(caseMem[base + NumNeurons]);
		if (classIndex !== expClass)
		begin
			$display("error classIndex: expected 0x%h, got 0x%h (case %0d)",
				expClass, classIndex, caseIdx);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		if (errorCount == errorsBefore)
		begin
			testsPassed++;
			$display("test %s: pass", name);
		end
		else
		begin
			testsFailed++;
			$display("test %s: fail with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	initial
	begin
		int    errorsBefore;
		int    edges;
		bit    seen;
		int    streamEdges;
		bit    streamSeen;
		string name;

		clk          = 1'b0;
		reset        = 1'b1;
		featureValid = 1'b0;
		featureData  = '0;
		lcgState     = 32'd68;
		errorCount   = 0;
		testsPassed  = 0;
		testsFailed  = 0;

		// Words the file does not overwrite keep a value no class index can take
		for (int i = 0; i < NumCases*CaseWords; i++)
		begin
			caseMem[i] = ~32'(i);
		end
		$readmemh("sim/layerCases.txt", caseMem);
		if (caseMem[NumCases*CaseWords-1] >= NumNeurons)
		begin
			$display("case file sim/layerCases.txt is missing or too short");
			errorCount++;
		end

		repeat (ResetCycles) tick();
		reset = 1'b0;

		errorsBefore = errorCount;
		for (int c = 0; c < 4; c++)
		begin
			tick();
			checkIdle();
		end
		reportTest("reset state", errorsBefore);

		// First vector with no gaps, outputs stay zero until its result
		errorsBefore = errorCount;
		sendVector(0, 1'b0);
		waitForResult(1'b1, edges, seen);
		// sendVector returns one edge after the last strobe
		if (seen && edges + 1 != PipeEdges)
		begin
			$display("resultValid came %0d edges after the last strobe instead of %0d",
				edges + 1, PipeEdges);
			errorCount++;
		end
		if (seen)
		begin
			checkResult(0);
		end
		reportTest("fixed latency", errorsBefore);

		for (int i = 0; i < NumCases; i++)
		begin
			errorsBefore = errorCount;
			sendVector(i, 1'b1);
			waitForResult(1'b0, edges, seen);
			if (seen)
			begin
				checkResult(i);
			end
			name = $sformatf("single case %0d", i);
			reportTest(name, errorsBefore);
		end

		// Vectors follow each other so several are in the pipeline at once
		errorsBefore = errorCount;
		fork
			begin
				for (int i = 0; i < NumCases; i++)
				begin
					sendVector(i, 1'b1);
				end
			end
			begin
				for (int i = 0; i < NumCases; i++)
				begin
					waitForResult(1'b0, streamEdges, streamSeen);
					if (streamSeen)
					begin
						checkResult(i);
					end
				end
			end
		join
		for (int c = 0; c < 10; c++)
		begin
			tick();
			if (resultValid !== 1'b0)
			begin
				$display("error resultValid: expected 0x0, got 0x%h", resultValid);
				errorCount++;
			end
		end
		reportTest("back-to-back stream", errorsBefore);

		$display("tests passed: %0d, tests failed: %0d, errors: %0d",
			testsPassed, testsFailed, errorCount);
		if (errorCount == 0 && testsFailed == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== sim/layerCases.txt ====
// One case per line: features f0 to f7, expected activations a0 to a3, expected class
// Features 0x1000 are half a unit of the 13 fraction bits
// Single positive feature
00001000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 073F 021F 0000 0985 3
// Mixed signs, neuron 2 negative
00002000 FFFFF000 00001000 00000000 FFFFF000 00000000 00001000 00000000 2215 022B 0000 0A5D 0
// Mixed signs, neuron 0 negative
FFFFF000 00002000 00000000 00001000 00001000 FFFFF000 00000000 00001000 0000 1756 1EE4 1193 2
// Every sum negative, tie goes to class 0
FFFFF000 00000000 00000000 00000000 00000000 00000000 00000000 FFFFF000 0000 0000 0000 0000 0
// Larger positive features
00000000 00003000 00000000 00002000 00000000 00000000 00001000 00000000 0000 2D8D 0933 03CD 1
// All features equal
00001000 00001000 00001000 00001000 00001000 00001000 00001000 00001000 0E1E 109F 0B92 1268 3
// Mixed signs, neuron 2 negative
00000000 00000000 00000000 00000000 FFFFE000 00000000 00000000 00003000 1962 055C 0000 1737 0
// Sums reach bits above 28, which the slice drops
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00040000 18FF 3460 6E3F 0280 2
// Zero vector, only the biases remain
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000 0000 0000 0000 0

// ==== tb.f ====
rtl/nnFormatPkg.sv
rtl/layerWeightsPkg.sv
rtl/featureCollector.sv
rtl/vectorLatch.sv
rtl/neuron.sv
rtl/denseLayer.sv
rtl/neuralLayerTop.sv
sim/neuralLayerTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run from the project root so the case file path resolves
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module neuralLayerTb \
	-f tb.f -o simv || exit 1
output="$(./obj_dir/simv 2>&1)"
echo "$output"
echo "$output" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1
